// ==== hdl/x86_pkg.sv ====
package x86_pkg;

   typedef logic [31:0] word_t;
   typedef logic [2:0]  gpr_id_t;

   // Opcode byte, ModRM byte, imm32 from high to low bits
   typedef struct packed {
      logic [7:0] opcode;
      logic [7:0] modrm;
      word_t      imm;
   } instr_t;

   localparam logic [7:0] OP_ADD_RM_R  = 8'h01;
   localparam logic [7:0] OP_OR_RM_R   = 8'h09;
   localparam logic [7:0] OP_AND_RM_R  = 8'h21;
   localparam logic [7:0] OP_SUB_RM_R  = 8'h29;
   localparam logic [7:0] OP_XOR_RM_R  = 8'h31;
   localparam logic [7:0] OP_CMP_RM_R  = 8'h39;
   localparam logic [7:0] OP_MOV_RM_R  = 8'h89;
   localparam logic [7:0] OP_GRP1_IMM  = 8'h81;
   // Base of B8..BF, register number in the low three bits
   localparam logic [7:0] OP_MOV_R_IMM = 8'hB8;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_OR     = 3'd1,
      ALU_AND    = 3'd2,
      ALU_SUB    = 3'd3,
      ALU_XOR    = 3'd4,
      ALU_PASS_B = 3'd5,
      ALU_CMP    = 3'd6
   } alu_op_t;

   typedef struct packed {
      logic cf;
      logic zf;
      logic sf;
   } flags_t;

   typedef struct packed {
      alu_op_t alu_op;
      gpr_id_t dest;
      gpr_id_t src_a;
      gpr_id_t src_b;
      logic    src_b_used;
      logic    use_imm;
      word_t   imm;
      logic    writes_reg;
      logic    writes_flags;
      logic    fault;
   } decoded_op_t;

   typedef struct packed {
      alu_op_t alu_op;
      gpr_id_t dest;
      word_t   a;
      word_t   b;
      logic    writes_reg;
      logic    writes_flags;
      logic    fault;
   } operand_t;

   typedef struct packed {
      gpr_id_t dest;
      word_t   data;
      flags_t  flags;
      logic    writes_reg;
      logic    writes_flags;
      logic    fault;
   } result_t;

endpackage

// ==== hdl/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
   parameter type T = logic [7:0]
) (
   input  logic clk,
   input  logic reset,
   input  logic in_valid,
   output logic in_ready,
   input  T     in_data,
   output logic out_valid,
   input  logic out_ready,
   output T     out_data
);

   // Free slot, or the held item leaves this same cycle
   assign in_ready = !out_valid || out_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out_data <= in_data;
      end
   end

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  x86_pkg::instr_t      instr,
   output logic                 dec_valid,
   input  logic                 dec_ready,
   output x86_pkg::decoded_op_t dec
);

   logic [1:0]           modrm_mod;
   logic [2:0]           modrm_reg;
   logic [2:0]           modrm_rm;
   logic                 is_grp1;
   logic                 is_mov_imm;
   logic                 alu_known;
   logic                 fault;
   x86_pkg::alu_op_t     alu_sel;
   x86_pkg::decoded_op_t dec_next;

   assign modrm_mod  = instr.modrm[7:6];
   assign modrm_reg  = instr.modrm[5:3];
   assign modrm_rm   = instr.modrm[2:0];
   assign is_grp1    = instr.opcode == x86_pkg::OP_GRP1_IMM;
   assign is_mov_imm = instr.opcode[7:3] == x86_pkg::OP_MOV_R_IMM[7:3];

   // Pick the ALU operation from the opcode, or the /digit for 0x81
   always_comb begin
      alu_known = 1'b1;
      alu_sel   = x86_pkg::ALU_PASS_B;
      case (instr.opcode)
         x86_pkg::OP_ADD_RM_R: alu_sel = x86_pkg::ALU_ADD;
         x86_pkg::OP_OR_RM_R:  alu_sel = x86_pkg::ALU_OR;
         x86_pkg::OP_AND_RM_R: alu_sel = x86_pkg::ALU_AND;
         x86_pkg::OP_SUB_RM_R: alu_sel = x86_pkg::ALU_SUB;
         x86_pkg::OP_XOR_RM_R: alu_sel = x86_pkg::ALU_XOR;
         x86_pkg::OP_CMP_RM_R: alu_sel = x86_pkg::ALU_CMP;
         x86_pkg::OP_MOV_RM_R: alu_sel = x86_pkg::ALU_PASS_B;
         x86_pkg::OP_GRP1_IMM: begin
            case (modrm_reg)
               3'd0:    alu_sel = x86_pkg::ALU_ADD;
               3'd1:    alu_sel = x86_pkg::ALU_OR;
               3'd4:    alu_sel = x86_pkg::ALU_AND;
               3'd5:    alu_sel = x86_pkg::ALU_SUB;
               3'd6:    alu_sel = x86_pkg::ALU_XOR;
               3'd7:    alu_sel = x86_pkg::ALU_CMP;
               default: alu_known = 1'b0;
            endcase
         end
         default: alu_known = is_mov_imm;
      endcase
   end

   // MOV r32,imm32 carries no ModRM, so mod only matters for the others
   assign fault = !alu_known || (!is_mov_imm && modrm_mod != 2'b11);

   always_comb begin
      dec_next              = '0;
      dec_next.alu_op       = alu_sel;
      dec_next.dest         = is_mov_imm ? instr.opcode[2:0] : modrm_rm;
      dec_next.src_a        = is_mov_imm ? instr.opcode[2:0] : modrm_rm;
      dec_next.src_b        = modrm_reg;
      dec_next.src_b_used   = !is_grp1 && !is_mov_imm;
      dec_next.use_imm      = is_grp1 || is_mov_imm;
      dec_next.imm          = instr.imm;
      dec_next.writes_reg   = !fault && alu_sel != x86_pkg::ALU_CMP;
      dec_next.writes_flags = !fault && alu_sel != x86_pkg::ALU_PASS_B;
      dec_next.fault        = fault;
   end

   pipe_stage #(
      .T(x86_pkg::decoded_op_t)
   ) u_dec_stage (
      .clk      (clk),
      .reset    (reset),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .in_data  (dec_next),
      .out_valid(dec_valid),
      .out_ready(dec_ready),
      .out_data (dec)
   );

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
   input  logic             clk,
   input  logic             reset,
   input  x86_pkg::gpr_id_t rd_addr_a,
   input  x86_pkg::gpr_id_t rd_addr_b,
   output x86_pkg::word_t   rd_data_a,
   output x86_pkg::word_t   rd_data_b,
   input  logic             wr_en,
   input  x86_pkg::gpr_id_t wr_addr,
   input  x86_pkg::word_t   wr_data
);

   // EAX..EDI in ModRM order
   x86_pkg::word_t regs [8];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // Reads see the old value during a write cycle
   assign rd_data_a = regs[rd_addr_a];
   assign rd_data_b = regs[rd_addr_b];

endmodule

// ==== hdl/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 dec_valid,
   output logic                 dec_ready,
   input  x86_pkg::decoded_op_t dec,
   output x86_pkg::gpr_id_t     rd_addr_a,
   output x86_pkg::gpr_id_t     rd_addr_b,
   input  x86_pkg::word_t       rd_data_a,
   input  x86_pkg::word_t       rd_data_b,
   input  logic                 commit_we,
   input  x86_pkg::gpr_id_t     commit_reg,
   output logic                 opnd_valid,
   input  logic                 opnd_ready,
   output x86_pkg::operand_t    opnd
);

   // One bit per register with a write still in flight
   logic [7:0]        pending;
   logic              hazard;
   logic              stage_ready;
   logic              issue;
   x86_pkg::operand_t opnd_next;

   assign rd_addr_a = dec.src_a;
   assign rd_addr_b = dec.src_b;

   assign hazard = pending[dec.src_a]
                 || (dec.src_b_used && pending[dec.src_b])
                 || pending[dec.dest];

   assign dec_ready = stage_ready && !hazard;
   assign issue     = dec_valid && dec_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= '0;
      end else begin
         if (commit_we) begin
            pending[commit_reg] <= 1'b0;
         end
         if (issue && dec.writes_reg) begin
            pending[dec.dest] <= 1'b1;
         end
      end
   end

   always_comb begin
      opnd_next              = '0;
      opnd_next.alu_op       = dec.alu_op;
      opnd_next.dest         = dec.dest;
      opnd_next.a            = rd_data_a;
      opnd_next.b            = dec.use_imm ? dec.imm : rd_data_b;
      opnd_next.writes_reg   = dec.writes_reg;
      opnd_next.writes_flags = dec.writes_flags;
      opnd_next.fault        = dec.fault;
   end

   pipe_stage #(
      .T(x86_pkg::operand_t)
   ) u_opnd_stage (
      .clk      (clk),
      .reset    (reset),
      .in_valid (dec_valid && !hazard),
      .in_ready (stage_ready),
      .in_data  (opnd_next),
      .out_valid(opnd_valid),
      .out_ready(opnd_ready),
      .out_data (opnd)
   );

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
   input  logic              clk,
   input  logic              reset,
   input  logic              opnd_valid,
   output logic              opnd_ready,
   input  x86_pkg::operand_t opnd,
   output logic              res_valid,
   input  logic              res_ready,
   output x86_pkg::result_t  res
);

   logic [32:0]      sum;
   x86_pkg::word_t   alu_data;
   logic             alu_cf;
   x86_pkg::result_t res_next;

   assign sum = {1'b0, opnd.a} + {1'b0, opnd.b};

   always_comb begin
      alu_cf = 1'b0;
      case (opnd.alu_op)
         x86_pkg::ALU_ADD: begin
            alu_data = sum[31:0];
            alu_cf   = sum[32];
         end
         // Borrow out, A below B unsigned
         x86_pkg::ALU_SUB, x86_pkg::ALU_CMP: begin
            alu_data = opnd.a - opnd.b;
            alu_cf   = opnd.a < opnd.b;
         end
         x86_pkg::ALU_OR:  alu_data = opnd.a | opnd.b;
         x86_pkg::ALU_AND: alu_data = opnd.a & opnd.b;
         x86_pkg::ALU_XOR: alu_data = opnd.a ^ opnd.b;
         default:          alu_data = opnd.b;
      endcase
   end

   always_comb begin
      res_next              = '0;
      res_next.dest         = opnd.dest;
      res_next.data         = alu_data;
      res_next.flags.cf     = alu_cf;
      res_next.flags.zf     = alu_data == '0;
      res_next.flags.sf     = alu_data[31];
      res_next.writes_reg   = opnd.writes_reg;
      res_next.writes_flags = opnd.writes_flags;
      res_next.fault        = opnd.fault;
   end

   pipe_stage #(
      .T(x86_pkg::result_t)
   ) u_res_stage (
      .clk      (clk),
      .reset    (reset),
      .in_valid (opnd_valid),
      .in_ready (opnd_ready),
      .in_data  (res_next),
      .out_valid(res_valid),
      .out_ready(res_ready),
      .out_data (res)
   );

endmodule

// ==== hdl/writeback_unit.sv ====
`timescale 1ns/1ps

module writeback_unit (
   input  logic             clk,
   input  logic             reset,
   input  logic             res_valid,
   output logic             res_ready,
   input  x86_pkg::result_t res,
   output logic             out_valid,
   input  logic             out_ready,
   output x86_pkg::gpr_id_t out_reg,
   output logic             out_write,
   output x86_pkg::word_t   out_data,
   output logic             out_fault,
   output x86_pkg::flags_t  eflags,
   output logic             wr_en,
   output x86_pkg::gpr_id_t wr_addr,
   output x86_pkg::word_t   wr_data
);

   logic commit;

   // Output side is a straight view of the execute register
   assign out_valid = res_valid;
   assign res_ready = out_ready;
   assign out_reg   = res.dest;
   assign out_write = res.writes_reg;
   assign out_data  = res.data;
   assign out_fault = res.fault;

   assign commit = res_valid && out_ready;

   assign wr_en   = commit && res.writes_reg;
   assign wr_addr = res.dest;
   assign wr_data = res.data;

   // Architectural flags, untouched by MOV and faults
   always_ff @(posedge clk) begin
      if (reset) begin
         eflags <= '0;
      end else if (commit && res.writes_flags) begin
         eflags <= res.flags;
      end
   end

endmodule

// ==== hdl/pipeline_top.sv ====
`timescale 1ns/1ps

module pipeline_top (
   input  logic             clk,
   input  logic             reset,
   input  logic             in_valid,
   output logic             in_ready,
   input  x86_pkg::instr_t  instr,
   output logic             out_valid,
   input  logic             out_ready,
   output x86_pkg::gpr_id_t out_reg,
   output logic             out_write,
   output x86_pkg::word_t   out_data,
   output logic             out_fault,
   output x86_pkg::flags_t  eflags
);

   logic                 dec_valid;
   logic                 dec_ready;
   x86_pkg::decoded_op_t dec;
   logic                 opnd_valid;
   logic                 opnd_ready;
   x86_pkg::operand_t    opnd;
   logic                 res_valid;
   logic                 res_ready;
   x86_pkg::result_t     res;
   x86_pkg::gpr_id_t     rd_addr_a;
   x86_pkg::gpr_id_t     rd_addr_b;
   x86_pkg::word_t       rd_data_a;
   x86_pkg::word_t       rd_data_b;
   // Commit port, shared by the register file and the scoreboard
   logic                 wr_en;
   x86_pkg::gpr_id_t     wr_addr;
   x86_pkg::word_t       wr_data;

   instr_decoder u_instr_decoder (
      .clk      (clk),
      .reset    (reset),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .instr    (instr),
      .dec_valid(dec_valid),
      .dec_ready(dec_ready),
      .dec      (dec)
   );

   operand_fetch u_operand_fetch (
      .clk       (clk),
      .reset     (reset),
      .dec_valid (dec_valid),
      .dec_ready (dec_ready),
      .dec       (dec),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .commit_we (wr_en),
      .commit_reg(wr_addr),
      .opnd_valid(opnd_valid),
      .opnd_ready(opnd_ready),
      .opnd      (opnd)
   );

   register_file u_register_file (
      .clk      (clk),
      .reset    (reset),
      .rd_addr_a(rd_addr_a),
      .rd_addr_b(rd_addr_b),
      .rd_data_a(rd_data_a),
      .rd_data_b(rd_data_b),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   execute_unit u_execute_unit (
      .clk       (clk),
      .reset     (reset),
      .opnd_valid(opnd_valid),
      .opnd_ready(opnd_ready),
      .opnd      (opnd),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res       (res)
   );

   writeback_unit u_writeback_unit (
      .clk      (clk),
      .reset    (reset),
      .res_valid(res_valid),
      .res_ready(res_ready),
      .res      (res),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .out_reg  (out_reg),
      .out_write(out_write),
      .out_data (out_data),
      .out_fault(out_fault),
      .eflags   (eflags),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

endmodule

// ==== tb/tb_pipeline.sv ====
`timescale 1ns/1ps

module tb_pipeline;

   localparam int N_INSTR     = 400;
   localparam int CLK_PERIOD  = 4;
   localparam int WATCHDOG_NS = N_INSTR * 40 * CLK_PERIOD;

   typedef struct packed {
      logic             fault;
      logic             write;
      x86_pkg::gpr_id_t dest;
      x86_pkg::word_t   data;
      x86_pkg::flags_t  flags;
   } expect_t;

   logic             clk       = 1'b0;
   logic             reset     = 1'b1;
   logic             in_valid  = 1'b0;
   logic             in_ready;
   x86_pkg::instr_t  instr     = '0;
   logic             out_valid;
   logic             out_ready = 1'b0;
   x86_pkg::gpr_id_t out_reg;
   logic             out_write;
   x86_pkg::word_t   out_data;
   logic             out_fault;
   x86_pkg::flags_t  eflags;

   integer           seed      = 32'h0f36_1ef7;
   logic [31:0]      stim_rnd;
   int               n_sent    = 0;
   int               n_in      = 0;
   int               n_out     = 0;
   logic             settled   = 1'b0;
   // Reference model, one step per accepted instruction
   x86_pkg::word_t   model_regs [8] = '{default: '0};
   x86_pkg::flags_t  model_flags    = '0;
   expect_t          exp_q [$];
   expect_t          exp_head       = '0;
   expect_t          new_exp;
   logic             have_exp       = 1'b0;
   x86_pkg::flags_t  last_flags     = '0;
   logic [36:0]      out_payload;
   logic [36:0]      prev_payload   = '0;

   pipeline_top DUT (
      .clk      (clk),
      .reset    (reset),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .instr    (instr),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .out_reg  (out_reg),
      .out_write(out_write),
      .out_data (out_data),
      .out_fault(out_fault),
      .eflags   (eflags)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   assign out_payload = {out_fault, out_write, out_reg, out_data};

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic mismatch(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
      fail_now($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected));
   endtask

   function automatic logic [31:0] rand32();
      return $random(seed);
   endfunction

   function automatic x86_pkg::instr_t random_instr();
      logic [31:0]     r;
      logic [2:0]      ra;
      logic [2:0]      rb;
      x86_pkg::instr_t ins;
      r = rand32();
      // Mostly EAX..EBX, so back-to-back hazards are common
      ra = (r[31:29] == 3'd0) ? r[2:0] : {1'b0, r[4:3]};
      rb = (r[28:26] == 3'd0) ? r[7:5] : {1'b0, r[9:8]};
      ins.modrm = {2'b11, rb, ra};
      ins.imm   = r[25] ? rand32() : {30'd0, r[24:23]};
      case (r[13:10])
         4'd0: ins.opcode = x86_pkg::OP_ADD_RM_R;
         4'd1: ins.opcode = x86_pkg::OP_OR_RM_R;
         4'd2: ins.opcode = x86_pkg::OP_AND_RM_R;
         4'd3: ins.opcode = x86_pkg::OP_SUB_RM_R;
         4'd4: ins.opcode = x86_pkg::OP_XOR_RM_R;
         4'd5: ins.opcode = x86_pkg::OP_CMP_RM_R;
         4'd6: ins.opcode = x86_pkg::OP_MOV_RM_R;
         // Any /digit, so /2 and /3 come up as faults
         4'd7, 4'd8, 4'd9: begin
            ins.opcode     = x86_pkg::OP_GRP1_IMM;
            ins.modrm[5:3] = r[16:14];
         end
         4'd10, 4'd11, 4'd12: ins.opcode = x86_pkg::OP_MOV_R_IMM | {5'd0, ra};
         4'd13: ins.opcode = r[21:14];
         4'd14: begin
            ins.opcode     = x86_pkg::OP_SUB_RM_R;
            ins.modrm[7:6] = r[15:14];
         end
         default: ins.opcode = x86_pkg::OP_XOR_RM_R;
      endcase
      return ins;
   endfunction

   task automatic apply_to_model(input x86_pkg::instr_t ins, output expect_t e);
      logic [2:0]  digit;
      logic [2:0]  rm;
      logic [31:0] a;
      logic [31:0] b;
      logic [32:0] wide;
      int          kind;
      digit = ins.modrm[5:3];
      rm    = ins.modrm[2:0];
      a     = model_regs[rm];
      b     = model_regs[digit];
      // 0 add, 1 or, 2 and, 3 sub, 4 xor, 5 cmp, 6 mov, -1 fault
      kind  = -1;
      case (ins.opcode)
         x86_pkg::OP_ADD_RM_R: kind = 0;
         x86_pkg::OP_OR_RM_R:  kind = 1;
         x86_pkg::OP_AND_RM_R: kind = 2;
         x86_pkg::OP_SUB_RM_R: kind = 3;
         x86_pkg::OP_XOR_RM_R: kind = 4;
         x86_pkg::OP_CMP_RM_R: kind = 5;
         x86_pkg::OP_MOV_RM_R: kind = 6;
         x86_pkg::OP_GRP1_IMM: begin
            b = ins.imm;
            case (digit)
               3'd0:    kind = 0;
               3'd1:    kind = 1;
               3'd4:    kind = 2;
               3'd5:    kind = 3;
               3'd6:    kind = 4;
               3'd7:    kind = 5;
               default: kind = -1;
            endcase
         end
         default: kind = -1;
      endcase
      if (ins.modrm[7:6] != 2'b11) begin
         kind = -1;
      end
      e.fault = 1'b0;
      e.write = 1'b1;
      e.dest  = rm;
      e.data  = '0;
      e.flags = model_flags;
      if ((ins.opcode & 8'hF8) == x86_pkg::OP_MOV_R_IMM) begin
         e.dest = ins.opcode[2:0];
         e.data = ins.imm;
      end else begin
         case (kind)
            0: begin
               wide       = {1'b0, a} + {1'b0, b};
               e.data     = wide[31:0];
               e.flags.cf = wide[32];
            end
            1: e.data = a | b;
            2: e.data = a & b;
            4: e.data = a ^ b;
            3, 5: begin
               e.data     = a - b;
               e.flags.cf = a < b;
            end
            6: e.data = b;
            default: begin
               e.fault = 1'b1;
               e.write = 1'b0;
            end
         endcase
         if (kind == 1 || kind == 2 || kind == 4) begin
            e.flags.cf = 1'b0;
         end
         if (kind >= 0 && kind <= 5) begin
            e.flags.zf = e.data == 32'd0;
            e.flags.sf = e.data[31];
         end
         if (kind == 5) begin
            e.write = 1'b0;
         end
      end
      if (e.write) begin
         model_regs[e.dest] = e.data;
      end
      model_flags = e.flags;
   endtask

   // Stimulus, model update and expected-result queue
   always @(posedge clk) begin
      settled      <= 1'b1;
      prev_payload <= out_payload;
      stim_rnd      = rand32();
      if (reset) begin
         in_valid  <= 1'b0;
         out_ready <= 1'b0;
      end else begin
         if (out_valid && out_ready && have_exp) begin
            last_flags <= exp_head.flags;
            exp_q.delete(0);
            n_out++;
         end
         if (in_valid && in_ready) begin
            apply_to_model(instr, new_exp);
            exp_q.push_back(new_exp);
            n_in++;
         end
         if (!in_valid || in_ready) begin
            if (n_sent < N_INSTR && stim_rnd[1:0] != 2'b00) begin
               in_valid <= 1'b1;
               instr    <= random_instr();
               n_sent++;
            end else begin
               in_valid <= 1'b0;
            end
         end
         // Every other block of 64 inputs runs under heavy back-pressure
         out_ready <= n_in[6] ? (stim_rnd[4:2] == 3'd0) : (stim_rnd[3:2] != 2'b00);
      end
      have_exp <= exp_q.size() != 0;
      if (exp_q.size() != 0) begin
         exp_head <= exp_q[0];
      end
   end

   // Reset values, also in the first cycle after reset
   assert property (@(posedge clk) ((reset && settled) || $fell(reset)) |-> !out_valid)
      else mismatch("out_valid", 64'($sampled(out_valid)), 64'd0);
   assert property (@(posedge clk) ((reset && settled) || $fell(reset)) |-> in_ready)
      else mismatch("in_ready", 64'($sampled(in_ready)), 64'd1);
   assert property (@(posedge clk) ((reset && settled) || $fell(reset)) |-> eflags == '0)
      else mismatch("eflags", 64'($sampled(eflags)), 64'd0);

   assert property (@(posedge clk) disable iff (reset) out_valid |-> have_exp)
      else fail_now("Output valid with no accepted instruction outstanding");

   // Results against the model, in order
   assert property (@(posedge clk) disable iff (reset)
                    (out_valid && out_ready) |-> out_fault == exp_head.fault)
      else mismatch("out_fault", 64'($sampled(out_fault)), 64'($sampled(exp_head.fault)));
   assert property (@(posedge clk) disable iff (reset)
                    (out_valid && out_ready) |-> out_write == exp_head.write)
      else mismatch("out_write", 64'($sampled(out_write)), 64'($sampled(exp_head.write)));
   assert property (@(posedge clk) disable iff (reset)
                    (out_valid && out_ready && !exp_head.fault) |-> out_reg == exp_head.dest)
      else mismatch("out_reg", 64'($sampled(out_reg)), 64'($sampled(exp_head.dest)));
   assert property (@(posedge clk) disable iff (reset)
                    (out_valid && out_ready && !exp_head.fault) |-> out_data == exp_head.data)
      else mismatch("out_data", 64'($sampled(out_data)), 64'($sampled(exp_head.data)));

   // Held output under back-pressure
   assert property (@(posedge clk) disable iff (reset) (out_valid && !out_ready) |=> out_valid)
      else mismatch("out_valid", 64'($sampled(out_valid)), 64'd1);
   assert property (@(posedge clk) disable iff (reset)
                    (out_valid && !out_ready) |=> out_payload == prev_payload)
      else mismatch("out_fault/out_write/out_reg/out_data",
                    64'($sampled(out_payload)), 64'($sampled(prev_payload)));

   assert property (@(posedge clk) disable iff (reset)
                    (out_valid && out_ready) |=> eflags == last_flags)
      else mismatch("eflags", 64'($sampled(eflags)), 64'($sampled(last_flags)));

   initial begin
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      while (!(n_out >= N_INSTR && exp_q.size() == 0)) begin
         @(negedge clk);
      end
      // One more cycle, so a stray output behind the last result shows up
      @(negedge clk);
      if (out_valid) begin
         fail_now("Output valid after every accepted instruction has completed");
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      fail_now($sformatf("Timeout after %0d ns with %0d of %0d results checked",
                         WATCHDOG_NS, n_out, N_INSTR));
   end

endmodule

// ==== all.f ====
hdl/x86_pkg.sv
hdl/pipe_stage.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/operand_fetch.sv
hdl/execute_unit.sv
hdl/writeback_unit.sv
hdl/pipeline_top.sv
tb/tb_pipeline.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_pipeline -Mdir obj_dir -f all.f \
   > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_pipeline > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "tests failed" "$SIM_LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
exit 0
